// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// one word, used for data, addresses and instructions
	localparam int word_w = 32;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00, // function field picks the op
		op_j     = 6'h02,
		op_jal   = 6'h03, // links into r31
		op_beq   = 6'h04,
		op_addi  = 6'h08, // sign-extended imm
		op_andi  = 6'h0c, // zero-extended imm
		op_ori   = 6'h0d, // zero-extended imm
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// r-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a // signed compare
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

	// next pc source
	typedef enum logic [1:0] {
		pc_seq,    // pc + 4
		pc_branch, // taken only with zero set
		pc_jump    // 26-bit index target
	} pc_sel_e;

	// write-back data source
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link // pc + 4 for jal
	} wb_sel_e;

	// destination register source
	typedef enum logic [1:0] {
		dst_rt,  // i-type
		dst_rd,  // r-type
		dst_r31  // jal link register
	} dst_sel_e;

endpackage

`default_nettype wire

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              run,         // low holds pc
	input  pc_sel_e           pc_sel,
	input  logic              branch,      // beq in flight
	input  logic              zero,        // from alu subtract
	input  logic [word_w-1:0] imm_ext,
	input  logic [word_w-1:0] jump_target,
	output logic [word_w-1:0] pc
);

	logic [word_w-1:0] pc_plus4;
	logic [word_w-1:0] branch_target;
	logic [word_w-1:0] pc_next;

	assign pc_plus4      = pc + word_w'(4);
	assign branch_target = pc_plus4 + {imm_ext[word_w-3:0], 2'b00}; // word offset to bytes

	always_comb begin
		case (pc_sel)
			pc_branch: pc_next = (branch && zero) ? branch_target : pc_plus4; // not taken falls through
			pc_jump:   pc_next = jump_target;
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0; // fetch starts at word 0
		end else if (run) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller
	import cpu_pkg::*;
(
	input  logic [word_w-1:0] instr,
	output logic [4:0]        rs,
	output logic [4:0]        rt,
	output logic [4:0]        rd,
	output logic [word_w-1:0] imm_ext,
	output logic [word_w-1:0] jump_target,
	output logic              alu_src,   // 1 = immediate as operand b
	output alu_op_e           alu_op,
	output logic              mem_we,
	output logic              reg_we,
	output wb_sel_e           wb_sel,
	output dst_sel_e          dst_sel,
	output logic              branch,
	output pc_sel_e           pc_sel
);

	opcode_e opcode;
	funct_e  funct;

	// field split
	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// logic ops zero-extend, everything else sign-extends
	assign imm_ext = (opcode == op_andi || opcode == op_ori) ?
		{16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	assign jump_target = {4'b0000, instr[25:0], 2'b00}; // top nibble held at zero

	always_comb begin
		// safe defaults: no writes, sequential flow
		alu_src = 1'b0;
		alu_op  = alu_add;
		mem_we  = 1'b0;
		reg_we  = 1'b0;
		wb_sel  = wb_alu;
		dst_sel = dst_rt;
		branch  = 1'b0;
		pc_sel  = pc_seq;
		case (opcode)
			op_rtype: begin
				dst_sel = dst_rd;
				reg_we  = 1'b1;
				case (funct)
					fn_add:  alu_op = alu_add;
					fn_sub:  alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_slt:  alu_op = alu_slt;
					default: reg_we = 1'b0; // unsupported funct, drop the write
				endcase
			end
			op_addi: begin
				alu_src = 1'b1;
				reg_we  = 1'b1;
			end
			op_andi: begin
				alu_src = 1'b1;
				alu_op  = alu_and;
				reg_we  = 1'b1;
			end
			op_ori: begin
				alu_src = 1'b1;
				alu_op  = alu_or;
				reg_we  = 1'b1;
			end
			op_lw: begin
				alu_src = 1'b1; // base + offset
				wb_sel  = wb_mem;
				reg_we  = 1'b1;
			end
			op_sw: begin
				alu_src = 1'b1;
				mem_we  = 1'b1; // no register write
			end
			op_beq: begin
				alu_op = alu_sub; // zero flag means equal
				branch = 1'b1;
				pc_sel = pc_branch;
			end
			op_j: pc_sel = pc_jump;
			op_jal: begin
				pc_sel  = pc_jump;
				wb_sel  = wb_link;
				dst_sel = dst_r31;
				reg_we  = 1'b1;
			end
			default: ; // unknown opcode, defaults stand
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  logic [word_w-1:0] rs_data,
	input  logic [word_w-1:0] rt_data,
	input  logic [word_w-1:0] imm_ext,
	input  logic              alu_src,
	input  alu_op_e           alu_op,
	output logic [word_w-1:0] result,
	output logic              zero
);

	logic [word_w-1:0] op_b;

	assign op_b = alu_src ? imm_ext : rt_data; // immediate or register

	always_comb begin
		case (alu_op)
			alu_add: result = rs_data + op_b;
			alu_sub: result = rs_data - op_b;
			alu_and: result = rs_data & op_b;
			alu_or:  result = rs_data | op_b;
			alu_slt: result = {{(word_w-1){1'b0}}, ($signed(rs_data) < $signed(op_b))};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // beq looks at this after sub

endmodule

`default_nettype wire

// ==== regfile/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              run,
	input  logic              reg_we,
	input  logic [4:0]        rs,
	input  logic [4:0]        rt,
	input  logic [4:0]        rd,
	input  dst_sel_e          dst_sel,
	input  wb_sel_e           wb_sel,
	input  logic [word_w-1:0] alu_result,
	input  logic [word_w-1:0] mem_data,
	input  logic [word_w-1:0] pc,
	output logic [word_w-1:0] rs_data,
	output logic [word_w-1:0] rt_data,
	output logic              ret_en,
	output logic [4:0]        ret_addr,
	output logic [word_w-1:0] ret_data
);

	logic [word_w-1:0] regs [32];
	logic [4:0]        wr_addr;
	logic [word_w-1:0] wr_data;

	always_comb begin
		case (dst_sel)
			dst_rd:  wr_addr = rd;
			dst_r31: wr_addr = 5'd31; // jal link
			default: wr_addr = rt;
		endcase
		case (wb_sel)
			wb_mem:  wr_data = mem_data;
			wb_link: wr_data = pc + word_w'(4); // return address
			default: wr_data = alu_result;
		endcase
	end

	// retire mirrors the write below exactly
	assign ret_en   = run && reg_we && (wr_addr != 5'd0);
	assign ret_addr = wr_addr;
	assign ret_data = wr_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (ret_en) begin
			regs[wr_addr] <= wr_data; // r0 never written, stays zero
		end
	end

	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

endmodule

`default_nettype wire

// ==== hw/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem
	import cpu_pkg::*;
#(
	parameter int imem_depth = 64
) (
	input  logic              clk,
	input  logic              load_en,   // one write per strobe cycle
	input  logic [word_w-1:0] load_addr, // byte address
	input  logic [word_w-1:0] load_data,
	input  logic [word_w-1:0] pc,
	output logic [word_w-1:0] instr
);

	localparam int aw = $clog2(imem_depth);

	logic [word_w-1:0] mem [imem_depth];

	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr[aw+1:2]] <= load_data; // drop byte offset
		end
	end

	assign instr = mem[pc[aw+1:2]]; // async fetch

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem
	import cpu_pkg::*;
#(
	parameter int dmem_depth = 64
) (
	input  logic              clk,
	input  logic              run,
	input  logic              mem_we,
	input  logic [word_w-1:0] addr,   // byte address from alu
	input  logic [word_w-1:0] wdata,
	output logic [word_w-1:0] rd_data
);

	localparam int aw = $clog2(dmem_depth);

	logic [word_w-1:0] mem [dmem_depth];

	always_ff @(posedge clk) begin
		if (mem_we && run) begin // halted core never stores
			mem[addr[aw+1:2]] <= wdata;
		end
	end

	assign rd_data = mem[addr[aw+1:2]]; // combinational for lw

endmodule

`default_nettype wire

// ==== hw/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu
	import cpu_pkg::*;
#(
	parameter int imem_depth = 64,
	parameter int dmem_depth = 64
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              run,       // low = halted, loading allowed
	input  logic              load_en,
	input  logic [word_w-1:0] load_addr,
	input  logic [word_w-1:0] load_data,
	output logic              ret_en,
	output logic [4:0]        ret_addr,
	output logic [word_w-1:0] ret_data
);

	// fetch
	logic [word_w-1:0] pc;
	logic [word_w-1:0] instr;

	// decode
	logic [4:0]        rs;
	logic [4:0]        rt;
	logic [4:0]        rd;
	logic [word_w-1:0] imm_ext;
	logic [word_w-1:0] jump_target;
	logic              alu_src;
	alu_op_e           alu_op;
	logic              mem_we;
	logic              reg_we;
	wb_sel_e           wb_sel;
	dst_sel_e          dst_sel;
	logic              branch;
	pc_sel_e           pc_sel;

	// execute and memory
	logic [word_w-1:0] rs_data;
	logic [word_w-1:0] rt_data;
	logic [word_w-1:0] result;
	logic              zero;
	logic [word_w-1:0] rd_data;

	pc_unit pc_unit0 (
		.clk(clk), .reset(reset), .run(run),
		.pc_sel(pc_sel), .branch(branch), .zero(zero),
		.imm_ext(imm_ext), .jump_target(jump_target),
		.pc(pc)
	);

	instr_mem #(.imem_depth(imem_depth)) instr_mem0 (
		.clk(clk), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .pc(pc), .instr(instr)
	);

	controller controller0 (
		.instr(instr),
		.rs(rs), .rt(rt), .rd(rd),
		.imm_ext(imm_ext), .jump_target(jump_target),
		.alu_src(alu_src), .alu_op(alu_op),
		.mem_we(mem_we), .reg_we(reg_we),
		.wb_sel(wb_sel), .dst_sel(dst_sel),
		.branch(branch), .pc_sel(pc_sel)
	);

	regfile regfile0 (
		.clk(clk), .reset(reset), .run(run), .reg_we(reg_we),
		.rs(rs), .rt(rt), .rd(rd),
		.dst_sel(dst_sel), .wb_sel(wb_sel),
		.alu_result(result), .mem_data(rd_data), .pc(pc),
		.rs_data(rs_data), .rt_data(rt_data),
		.ret_en(ret_en), .ret_addr(ret_addr), .ret_data(ret_data)
	);

	alu alu0 (
		.rs_data(rs_data), .rt_data(rt_data), .imm_ext(imm_ext),
		.alu_src(alu_src), .alu_op(alu_op),
		.result(result), .zero(zero)
	);

	data_mem #(.dmem_depth(dmem_depth)) data_mem0 (
		.clk(clk), .run(run), .mem_we(mem_we),
		.addr(result), .wdata(rt_data), // sw stores rt
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_properties
	import cpu_pkg::*;
(
	input logic              clk,
	input logic              reset,
	input logic              run,
	input logic              ret_en,
	input logic [4:0]        ret_addr,
	input logic [word_w-1:0] pc
);

	// r0 writes must be swallowed
	retire_not_r0: assert property (@(posedge clk) disable iff (reset)
		ret_en |-> ret_addr != 5'd0)
		else $error("retire reported a write to r0");

	// halted core keeps its pc
	pc_hold: assert property (@(posedge clk) disable iff (reset)
		!run |=> $stable(pc))
		else $error("pc moved while run was low");

	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("pc not word aligned");

endmodule

bind regfile cpu_properties props0 (
	.clk(clk), .reset(reset), .run(run),
	.ret_en(ret_en), .ret_addr(ret_addr), .pc(pc)
);

`default_nettype wire

// ==== verif/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              ret_en,
	input  logic [4:0]        ret_addr,
	input  logic [word_w-1:0] ret_data,
	output logic              all_seen,  // every queued write has retired
	output int                n_pass,
	output int                n_fail
);

	// expected writes in program order
	int                exp_test [$];
	logic [4:0]        exp_addr [$];
	logic [word_w-1:0] exp_data [$];

	int                cur_test;
	logic [4:0]        cur_addr;
	logic [word_w-1:0] cur_data;

	initial begin
		n_pass   = 0;
		n_fail   = 0;
		all_seen = 1'b0;
	end

	// queued by the testbench while it loads the program
	task automatic expect_write(input int test, input logic [4:0] addr,
			input logic [word_w-1:0] data);
		exp_test.push_back(test);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// whatever is left never showed up on the retire port
	task automatic report_missing();
		while (exp_test.size() > 0) begin
			cur_test = exp_test.pop_front();
			cur_addr = exp_addr.pop_front();
			cur_data = exp_data.pop_front();
			$display("test %0d: write of r%0d = %h never retired", cur_test, cur_addr, cur_data);
			n_fail++;
		end
	endtask

	// retire outputs settle before the edge, read the pre-edge values
	always @(posedge clk) begin
		if (!reset && ret_en) begin
			if (exp_test.size() == 0) begin
				$display("unexpected write of r%0d = %h after all expected writes retired",
					ret_addr, ret_data);
				n_fail++;
			end else begin
				cur_test = exp_test.pop_front();
				cur_addr = exp_addr.pop_front();
				cur_data = exp_data.pop_front();
				if (ret_addr === cur_addr && ret_data === cur_data) begin
					$display("test %0d: r%0d = %h ok", cur_test, ret_addr, ret_data);
					n_pass++;
				end else begin
					$display("** Error test %0d: ret_addr = %h ret_data = %h, expected %h / %h",
						cur_test, ret_addr, ret_data, cur_addr, cur_data);
					n_fail++;
				end
				if (exp_test.size() == 0)
					all_seen = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
();

	logic              clk;
	logic              reset;
	logic              run;
	logic              load_en;
	logic [word_w-1:0] load_addr;
	logic [word_w-1:0] load_data;
	logic              ret_en;
	logic [4:0]        ret_addr;
	logic [word_w-1:0] ret_data;
	logic              all_seen;
	int                n_pass;
	int                n_fail;
	int                n_exp;

	// program table, one entry per instruction word
	logic [word_w-1:0] prog_instr [$];
	logic              prog_has [$];  // entry retires a write
	logic [4:0]        prog_reg [$];
	logic [word_w-1:0] prog_val [$];

	cpu #(.imem_depth(64), .dmem_depth(64)) dut0 (
		.clk(clk), .reset(reset), .run(run),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.ret_en(ret_en), .ret_addr(ret_addr), .ret_data(ret_data)
	);

	cpu_checker chk0 (
		.clk(clk), .reset(reset),
		.ret_en(ret_en), .ret_addr(ret_addr), .ret_data(ret_data),
		.all_seen(all_seen), .n_pass(n_pass), .n_fail(n_fail)
	);

	function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input funct_e fn);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_word(input opcode_e op, input logic [25:0] index);
		return {op, index};
	endfunction

	task automatic add_entry(input logic [31:0] instr, input logic has,
			input logic [4:0] rg, input logic [31:0] val);
		prog_instr.push_back(instr);
		prog_has.push_back(has);
		prog_reg.push_back(rg);
		prog_val.push_back(val);
	endtask

	// expected values worked out by hand from the instruction rules
	task automatic build_program();
		add_entry(itype_word(op_addi, 0, 1, 16'd5), 1, 1, 32'h0000_0005);    // 0
		add_entry(itype_word(op_ori, 0, 2, 16'h00f0), 1, 2, 32'h0000_00f0);  // 1
		add_entry(rtype_word(1, 2, 3, fn_add), 1, 3, 32'h0000_00f5);         // 2
		add_entry(rtype_word(1, 2, 4, fn_sub), 1, 4, 32'hffff_ff15);         // 3: 5 - 240
		add_entry(rtype_word(3, 2, 5, fn_and), 1, 5, 32'h0000_00f0);         // 4
		add_entry(rtype_word(1, 2, 6, fn_or), 1, 6, 32'h0000_00f5);          // 5
		add_entry(rtype_word(4, 1, 7, fn_slt), 1, 7, 32'h0000_0001);         // 6: -235 < 5
		add_entry(rtype_word(1, 4, 8, fn_slt), 1, 8, 32'h0000_0000);         // 7
		add_entry(itype_word(op_addi, 1, 9, 16'hfff8), 1, 9, 32'hffff_fffd); // 8: 5 + -8
		add_entry(itype_word(op_andi, 4, 10, 16'hff0f), 1, 10, 32'h0000_ff05); // 9: zero ext
		add_entry(itype_word(op_ori, 0, 11, 16'h8001), 1, 11, 32'h0000_8001);  // 10
		add_entry(itype_word(op_sw, 0, 6, 16'd8), 0, 0, 0);                  // 11: mem[8] = r6
		add_entry(itype_word(op_lw, 0, 12, 16'd8), 1, 12, 32'h0000_00f5);    // 12
		add_entry(itype_word(op_beq, 1, 1, 16'd1), 0, 0, 0);                 // 13: taken
		add_entry(itype_word(op_addi, 0, 13, 16'h0bad), 0, 0, 0);            // 14: skipped
		add_entry(itype_word(op_beq, 1, 2, 16'd1), 0, 0, 0);                 // 15: not taken
		add_entry(itype_word(op_addi, 0, 13, 16'd7), 1, 13, 32'h0000_0007);  // 16
		add_entry(jump_word(op_jal, 26'd19), 1, 31, 32'h0000_0048);          // 17: link 17*4+4
		add_entry(itype_word(op_addi, 0, 14, 16'h0bad), 0, 0, 0);            // 18: skipped
		add_entry(jump_word(op_j, 26'd21), 0, 0, 0);                         // 19
		add_entry(itype_word(op_addi, 0, 14, 16'h0bad), 0, 0, 0);            // 20: skipped
		add_entry(itype_word(op_addi, 1, 0, 16'd9), 0, 0, 0);                // 21: r0 dropped
		add_entry(rtype_word(0, 3, 15, fn_add), 1, 15, 32'h0000_00f5);       // 22
		add_entry(rtype_word(11, 0, 16, fn_add), 1, 16, 32'h0000_8001);      // 23
		add_entry(jump_word(op_j, 26'd24), 0, 0, 0);                         // 24: park here
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset     = 1'b1;
		run       = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		n_exp     = 0;
		build_program();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// load with the core halted, one word per cycle
		for (int i = 0; i < prog_instr.size(); i++) begin
			load_en   = 1'b1;
			load_addr = word_w'(i * 4);
			load_data = prog_instr[i];
			if (prog_has[i]) begin
				chk0.expect_write(i, prog_reg[i], prog_val[i]);
				n_exp++;
			end
			@(negedge clk);
		end
		load_en = 1'b0;
		run     = 1'b1;
		wait (all_seen === 1'b1);
		repeat (4) @(negedge clk); // park loop must stay quiet
		$display("%0d checks passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0 && n_pass == n_exp) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// one cycle per table entry plus slack, counted from run
	initial begin
		wait (run === 1'b1);
		#((prog_instr.size() + 20) * 100);
		$display("timeout: expected writes still outstanding after %0d cycles of run",
			prog_instr.size() + 20);
		chk0.report_missing();
		#1;
		$display("%0d checks passed, %0d failed", n_pass, n_fail);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
common/cpu_pkg.sv
hw/pc_unit.sv
hw/controller.sv
hw/alu.sv
regfile/regfile.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/cpu.sv
verif/cpu_properties.sv
verif/cpu_checker.sv
verif/cpu_tb.sv
